//--- logic/xbar_pkg.sv
//////////////////////////////////////////////////////////////////////
// AXI4-Lite crossbar package
// Widths, port counts, fixed address map, response codes and the
// channel and link structs shared by every crossbar stage
//////////////////////////////////////////////////////////////////////
package xbar_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;

  localparam int unsigned N_INIT = 2;  // Initiator ports
  localparam int unsigned N_TGT  = 2;  // Target ports
  localparam int unsigned SEL_W  = 2;  // Route select, N_TGT is the error route

  // Address map, a hit is (addr & MASK) == BASE
  localparam logic [ADDR_W-1:0] TGT0_BASE = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] TGT0_MASK = 32'hffff_f000;
  localparam logic [ADDR_W-1:0] TGT1_BASE = 32'h0000_1000;
  localparam logic [ADDR_W-1:0] TGT1_MASK = 32'hffff_f000;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [2:0]        prot;
  } ax_chan_t;  // Shared by AW and AR

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } w_chan_t;

  typedef struct packed {
    resp_e resp;
  } b_chan_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    resp_e             resp;
  } r_chan_t;

  // Upstream side of a link
  typedef struct packed {
    logic     aw_valid;
    ax_chan_t aw;
    logic     w_valid;
    w_chan_t  w;
    logic     b_ready;
    logic     ar_valid;
    ax_chan_t ar;
    logic     r_ready;
  } lite_req_t;

  // Downstream side of a link
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    logic    b_valid;
    b_chan_t b;
    logic    ar_ready;
    logic    r_valid;
    r_chan_t r;
  } lite_resp_t;

endpackage

//--- logic/xbar_demux.sv
//////////////////////////////////////////////////////////////////////
// AXI4-Lite crossbar demultiplexer
// Decodes AW and AR addresses against the fixed map and steers each
// request to one target route or to the decode-error route. One
// write and one read may be outstanding, each with a latched route.
//////////////////////////////////////////////////////////////////////
module xbar_demux import xbar_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  lite_req_t              init_req_i,
  output lite_resp_t             init_resp_o,
  output lite_req_t  [N_TGT:0]   route_reqs_o,
  input  lite_resp_t [N_TGT:0]   route_resps_i
);

  logic [SEL_W-1:0] aw_dec, ar_dec;      // Decoded routes of the live requests
  logic [SEL_W-1:0] aw_sel_q, ar_sel_q;  // Routes of the outstanding transactions
  logic             wr_busy_q;           // Write accepted, waiting for B
  logic             w_sent_q;            // W of that write forwarded
  logic             rd_busy_q;           // Read accepted, waiting for R
  logic             aw_hs, w_hs, b_hs, ar_hs, r_hs;

  // Unmapped addresses fall through to the error route
  function automatic logic [SEL_W-1:0] addr_decode(input logic [ADDR_W-1:0] addr);
    if ((addr & TGT0_MASK) == TGT0_BASE) begin
      return SEL_W'(0);
    end
    if ((addr & TGT1_MASK) == TGT1_BASE) begin
      return SEL_W'(1);
    end
    return SEL_W'(N_TGT);
  endfunction

  assign aw_dec = addr_decode(init_req_i.aw.addr);
  assign ar_dec = addr_decode(init_req_i.ar.addr);

  always_comb begin
    init_resp_o = '0;
    for (int k = 0; k <= N_TGT; k++) begin
      route_reqs_o[k]    = '0;
      route_reqs_o[k].aw = init_req_i.aw;  // Payloads fan out, valids are steered
      route_reqs_o[k].w  = init_req_i.w;
      route_reqs_o[k].ar = init_req_i.ar;
    end

    // Write path
    if (!wr_busy_q) begin
      route_reqs_o[aw_dec].aw_valid = init_req_i.aw_valid;
      init_resp_o.aw_ready          = route_resps_i[aw_dec].aw_ready;
    end else if (!w_sent_q) begin
      route_reqs_o[aw_sel_q].w_valid = init_req_i.w_valid;
      init_resp_o.w_ready            = route_resps_i[aw_sel_q].w_ready;
    end else begin
      route_reqs_o[aw_sel_q].b_ready = init_req_i.b_ready;
      init_resp_o.b_valid            = route_resps_i[aw_sel_q].b_valid;
      init_resp_o.b                  = route_resps_i[aw_sel_q].b;
    end

    // Read path
    if (!rd_busy_q) begin
      route_reqs_o[ar_dec].ar_valid = init_req_i.ar_valid;
      init_resp_o.ar_ready          = route_resps_i[ar_dec].ar_ready;
    end else begin
      route_reqs_o[ar_sel_q].r_ready = init_req_i.r_ready;
      init_resp_o.r_valid            = route_resps_i[ar_sel_q].r_valid;
      init_resp_o.r                  = route_resps_i[ar_sel_q].r;
    end
  end

  assign aw_hs = init_req_i.aw_valid & init_resp_o.aw_ready;
  assign w_hs  = init_req_i.w_valid  & init_resp_o.w_ready;
  assign b_hs  = init_resp_o.b_valid & init_req_i.b_ready;
  assign ar_hs = init_req_i.ar_valid & init_resp_o.ar_ready;
  assign r_hs  = init_resp_o.r_valid & init_req_i.r_ready;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_busy_q <= 1'b0;
      w_sent_q  <= 1'b0;
      rd_busy_q <= 1'b0;
      aw_sel_q  <= '0;
      ar_sel_q  <= '0;
    end else begin
      if (aw_hs) begin
        wr_busy_q <= 1'b1;
        aw_sel_q  <= aw_dec;  // Route stays fixed until B
      end
      if (w_hs) w_sent_q <= 1'b1;
      if (b_hs) begin
        wr_busy_q <= 1'b0;
        w_sent_q  <= 1'b0;
      end
      if (ar_hs) begin
        rd_busy_q <= 1'b1;
        ar_sel_q  <= ar_dec;
      end else if (r_hs) begin
        rd_busy_q <= 1'b0;
      end
    end
  end

endmodule

//--- logic/xbar_err_slv.sv
//////////////////////////////////////////////////////////////////////
// Decode-error responder
// Terminates unmapped AXI4-Lite writes with B DECERR and reads with
// R DECERR and zero data
//////////////////////////////////////////////////////////////////////
module xbar_err_slv import xbar_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  lite_req_t  req_i,
  output lite_resp_t resp_o
);

  logic aw_q, w_q, b_q;  // AW taken, W taken, B pending
  logic r_q;             // R pending
  logic aw_done, w_done;

  always_comb begin
    resp_o          = '0;
    resp_o.aw_ready = !aw_q;  // Each half taken once per write
    resp_o.w_ready  = !w_q;
    resp_o.b_valid  = b_q;
    resp_o.b.resp   = RESP_DECERR;
    resp_o.ar_ready = !r_q;
    resp_o.r_valid  = r_q;
    resp_o.r.data   = '0;
    resp_o.r.resp   = RESP_DECERR;
  end

  // AW and W may arrive in either order
  assign aw_done = aw_q | (req_i.aw_valid & !aw_q);
  assign w_done  = w_q  | (req_i.w_valid  & !w_q);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      aw_q <= 1'b0;
      w_q  <= 1'b0;
      b_q  <= 1'b0;
      r_q  <= 1'b0;
    end else begin
      if (b_q && req_i.b_ready) begin
        aw_q <= 1'b0;
        w_q  <= 1'b0;
        b_q  <= 1'b0;
      end else begin
        aw_q <= aw_done;
        w_q  <= w_done;
        b_q  <= aw_done & w_done;  // Response one cycle after both halves
      end
      if (r_q) r_q <= !req_i.r_ready;
      else     r_q <= req_i.ar_valid;
    end
  end

endmodule

//--- logic/xbar_mux.sv
//////////////////////////////////////////////////////////////////////
// AXI4-Lite crossbar multiplexer
// Round-robin arbitration of AW and AR between initiators for one
// target. The winner owns W and B, or R, until its response is taken.
//////////////////////////////////////////////////////////////////////
module xbar_mux import xbar_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  lite_req_t  [N_INIT-1:0]   init_reqs_i,
  output lite_resp_t [N_INIT-1:0]   init_resps_o,
  output lite_req_t                 tgt_req_o,
  input  lite_resp_t                tgt_resp_i
);

  typedef logic [$clog2(N_INIT)-1:0] idx_t;

  logic [N_INIT-1:0] aw_req, ar_req;
  idx_t              aw_gnt, ar_gnt;
  idx_t              aw_last_q, ar_last_q;    // Last winners
  idx_t              wr_owner_q, rd_owner_q;  // Held or locked requesters
  logic              aw_hold_q, ar_hold_q;    // Offer made, not yet accepted
  logic              wr_busy_q, rd_busy_q;    // Locked until B or R
  logic              w_done_q;
  logic              aw_hs, w_hs, b_hs, ar_hs, r_hs;

  // First requester after the last winner
  function automatic idx_t rr_pick(input logic [N_INIT-1:0] req, input idx_t last);
    idx_t cand;
    logic found;
    rr_pick = last;
    found   = 1'b0;
    for (int k = 1; k <= N_INIT; k++) begin
      cand = idx_t'((int'(last) + k) % N_INIT);
      if (!found && req[cand]) begin
        rr_pick = cand;
        found   = 1'b1;
      end
    end
  endfunction

  always_comb begin
    for (int i = 0; i < N_INIT; i++) begin
      aw_req[i] = init_reqs_i[i].aw_valid;
      ar_req[i] = init_reqs_i[i].ar_valid;
    end
  end

  // A pending offer keeps its winner so the target sees a stable request
  assign aw_gnt = aw_hold_q ? wr_owner_q : rr_pick(aw_req, aw_last_q);
  assign ar_gnt = ar_hold_q ? rd_owner_q : rr_pick(ar_req, ar_last_q);

  always_comb begin
    tgt_req_o          = '0;
    tgt_req_o.aw_valid = !wr_busy_q && (|aw_req);
    tgt_req_o.aw       = init_reqs_i[aw_gnt].aw;
    tgt_req_o.w_valid  = wr_busy_q && !w_done_q && init_reqs_i[wr_owner_q].w_valid;
    tgt_req_o.w        = init_reqs_i[wr_owner_q].w;
    tgt_req_o.b_ready  = wr_busy_q && w_done_q && init_reqs_i[wr_owner_q].b_ready;
    tgt_req_o.ar_valid = !rd_busy_q && (|ar_req);
    tgt_req_o.ar       = init_reqs_i[ar_gnt].ar;
    tgt_req_o.r_ready  = rd_busy_q && init_reqs_i[rd_owner_q].r_ready;

    for (int i = 0; i < N_INIT; i++) begin
      init_resps_o[i]          = '0;
      init_resps_o[i].aw_ready = !wr_busy_q && (aw_gnt == idx_t'(i)) && tgt_resp_i.aw_ready;
      init_resps_o[i].w_ready  = wr_busy_q && !w_done_q && (wr_owner_q == idx_t'(i))
                                 && tgt_resp_i.w_ready;
      init_resps_o[i].b_valid  = wr_busy_q && w_done_q && (wr_owner_q == idx_t'(i))
                                 && tgt_resp_i.b_valid;
      init_resps_o[i].b        = tgt_resp_i.b;
      init_resps_o[i].ar_ready = !rd_busy_q && (ar_gnt == idx_t'(i)) && tgt_resp_i.ar_ready;
      init_resps_o[i].r_valid  = rd_busy_q && (rd_owner_q == idx_t'(i)) && tgt_resp_i.r_valid;
      init_resps_o[i].r        = tgt_resp_i.r;
    end
  end

  assign aw_hs = tgt_req_o.aw_valid & tgt_resp_i.aw_ready;
  assign w_hs  = tgt_req_o.w_valid  & tgt_resp_i.w_ready;
  assign b_hs  = tgt_resp_i.b_valid & tgt_req_o.b_ready;
  assign ar_hs = tgt_req_o.ar_valid & tgt_resp_i.ar_ready;
  assign r_hs  = tgt_resp_i.r_valid & tgt_req_o.r_ready;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      aw_last_q  <= '0;
      ar_last_q  <= '0;
      wr_owner_q <= '0;
      rd_owner_q <= '0;
      aw_hold_q  <= 1'b0;
      ar_hold_q  <= 1'b0;
      wr_busy_q  <= 1'b0;
      rd_busy_q  <= 1'b0;
      w_done_q   <= 1'b0;
    end else begin
      if (tgt_req_o.aw_valid) begin
        wr_owner_q <= aw_gnt;
        aw_hold_q  <= !aw_hs;
      end
      if (aw_hs) begin
        wr_busy_q <= 1'b1;
        aw_last_q <= aw_gnt;
      end
      if (w_hs) w_done_q <= 1'b1;
      if (b_hs) begin
        wr_busy_q <= 1'b0;
        w_done_q  <= 1'b0;
      end
      if (tgt_req_o.ar_valid) begin
        rd_owner_q <= ar_gnt;
        ar_hold_q  <= !ar_hs;
      end
      if (ar_hs) begin
        rd_busy_q <= 1'b1;
        ar_last_q <= ar_gnt;
      end else if (r_hs) begin
        rd_busy_q <= 1'b0;
      end
    end
  end

endmodule

//--- logic/xbar_top.sv
//////////////////////////////////////////////////////////////////////
// AXI4-Lite crossbar, 2 initiators by 2 targets
// One demultiplexer and decode-error responder per initiator, one
// multiplexer per target, fully connected in between
//////////////////////////////////////////////////////////////////////
module xbar_top import xbar_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  lite_req_t  [N_INIT-1:0]   init_reqs_i,
  output lite_resp_t [N_INIT-1:0]   init_resps_o,
  output lite_req_t  [N_TGT-1:0]    tgt_reqs_o,
  input  lite_resp_t [N_TGT-1:0]    tgt_resps_i
);

  // Demux side, the extra route is the error responder
  lite_req_t  [N_INIT-1:0][N_TGT:0]    route_reqs;
  lite_resp_t [N_INIT-1:0][N_TGT:0]    route_resps;

  // Mux side, indexed target first
  lite_req_t  [N_TGT-1:0][N_INIT-1:0]  mux_reqs;
  lite_resp_t [N_TGT-1:0][N_INIT-1:0]  mux_resps;

  for (genvar i = 0; i < N_INIT; i++) begin : gen_init
    xbar_demux demux_i (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .init_req_i    (init_reqs_i[i]),
      .init_resp_o   (init_resps_o[i]),
      .route_reqs_o  (route_reqs[i]),
      .route_resps_i (route_resps[i])
    );

    xbar_err_slv err_slv_i (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (route_reqs[i][N_TGT]),
      .resp_o  (route_resps[i][N_TGT])
    );

    for (genvar j = 0; j < N_TGT; j++) begin : gen_cross
      assign mux_reqs[j][i]    = route_reqs[i][j];  // Route j of initiator i
      assign route_resps[i][j] = mux_resps[j][i];
    end
  end

  for (genvar j = 0; j < N_TGT; j++) begin : gen_tgt
    xbar_mux mux_i (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .init_reqs_i  (mux_reqs[j]),
      .init_resps_o (mux_resps[j]),
      .tgt_req_o    (tgt_reqs_o[j]),
      .tgt_resp_i   (tgt_resps_i[j])
    );
  end

endmodule

//--- dv/xbar_chk.sv
//////////////////////////////////////////////////////////////////////
// Crossbar multiplexer checker
// Handshake stability, write-owner routing and reset rules at the
// target side of each multiplexer
//////////////////////////////////////////////////////////////////////
module xbar_chk import xbar_pkg::*; (
  input logic                         clk_i,
  input logic                         rst_n_i,
  input lite_req_t  [N_INIT-1:0]      init_reqs_i,
  input lite_resp_t [N_INIT-1:0]      init_resps_o,
  input lite_req_t                    tgt_req_o,
  input lite_resp_t                   tgt_resp_i
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [N_INIT-1:0] aw_won;   // Initiator whose AW the target took last
  logic [N_INIT-1:0] w_taken;  // Initiators offered w_ready
  w_chan_t           won_w;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      aw_won <= '0;
    end else if (tgt_req_o.aw_valid && tgt_resp_i.aw_ready) begin
      for (int i = 0; i < N_INIT; i++) begin
        aw_won[i] <= init_reqs_i[i].aw_valid && init_resps_o[i].aw_ready;
      end
    end
  end

  always_comb begin
    won_w = '0;
    for (int i = 0; i < N_INIT; i++) begin
      w_taken[i] = init_resps_o[i].w_ready;
      if (aw_won[i]) won_w = init_reqs_i[i].w;
    end
  end

  aw_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tgt_req_o.aw_valid && !tgt_resp_i.aw_ready |=> tgt_req_o.aw_valid && $stable(tgt_req_o.aw))
    else $error("AW dropped or changed before its handshake");

  w_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tgt_req_o.w_valid && !tgt_resp_i.w_ready |=> tgt_req_o.w_valid && $stable(tgt_req_o.w))
    else $error("W dropped or changed before its handshake");

  ar_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tgt_req_o.ar_valid && !tgt_resp_i.ar_ready |=> tgt_req_o.ar_valid && $stable(tgt_req_o.ar))
    else $error("AR dropped or changed before its handshake");

  // W may only come from the initiator whose AW the target accepted
  w_owner: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (w_taken & ~aw_won) == '0
    && (!tgt_req_o.w_valid || ($onehot(aw_won) && tgt_req_o.w == won_w)))
    else $error("W forwarded from an initiator that does not own the write");

  rst_quiet: assert property (@(posedge clk_i)
    !rst_n_i |-> !(tgt_req_o.aw_valid || tgt_req_o.w_valid || tgt_req_o.ar_valid))
    else $error("Valid toward the target during reset");

endmodule

bind xbar_mux xbar_chk chk_i (.*);

//--- dv/tb_xbar.sv
//////////////////////////////////////////////////////////////////////
// AXI4-Lite crossbar testbench
// Two initiator drivers replay the golden transactions, two target
// memory models answer them, with and without random back-pressure
//////////////////////////////////////////////////////////////////////
module tb_xbar import xbar_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PERIOD  = 20;
  localparam int SKEW    = 9;   // Sample point just before the rising edge
  localparam int MAX_OPS = 64;

  logic                     clk_i, rst_n_i;
  lite_req_t  [N_INIT-1:0]  init_reqs;
  lite_resp_t [N_INIT-1:0]  init_resps;
  lite_req_t  [N_TGT-1:0]   tgt_reqs;
  lite_resp_t [N_TGT-1:0]   tgt_resps;

  logic [31:0] g_init[MAX_OPS], g_wr[MAX_OPS], g_addr[MAX_OPS], g_data[MAX_OPS];
  logic [31:0] g_strb[MAX_OPS], g_exp[MAX_OPS], g_resp[MAX_OPS];
  int          n_ops, errors, n_pass, n_fail;
  int          exp_cnt[N_TGT], xfer_cnt[N_TGT];
  logic [31:0] rng;
  logic        stall_en;

  // Target model state
  logic [31:0] mem[N_TGT][1024];
  logic        aw_f[N_TGT], w_f[N_TGT], b_v[N_TGT], r_v[N_TGT];
  logic [9:0]  aw_idx[N_TGT];
  logic [31:0] w_d[N_TGT], r_d[N_TGT];
  logic [3:0]  w_s[N_TGT];

  xbar_top dut_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .init_reqs_i  (init_reqs),
    .init_resps_o (init_resps),
    .tgt_reqs_o   (tgt_reqs),
    .tgt_resps_i  (tgt_resps)
  );

  function automatic logic [31:0] xorshift32();
    rng ^= rng << 13;
    rng ^= rng >> 17;
    rng ^= rng << 5;
    return rng;
  endfunction

  function automatic logic ready_draw();
    logic [31:0] v;
    if (!stall_en) return 1'b1;
    v = xorshift32();
    return v[1:0] != 2'b00;  // Ready about 3 cycles in 4
  endfunction

  // Protection bits follow the address so a swapped payload shows up
  function automatic logic [2:0] prot_for(input logic [31:0] addr);
    return addr[4:2] ^ addr[10:8];
  endfunction

  function automatic logic any_valid();
    logic v;
    v = 1'b0;
    for (int j = 0; j < N_TGT; j++)
      v |= tgt_reqs[j].aw_valid | tgt_reqs[j].w_valid | tgt_reqs[j].ar_valid;
    for (int i = 0; i < N_INIT; i++) v |= init_resps[i].b_valid | init_resps[i].r_valid;
    return v;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("error t=%0t %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic load_golden();
    int          fd;
    string       line;
    logic [31:0] f[7];
    fd = $fopen("dv/xbar_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open the golden transaction file");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) > 0) begin
        if ($sscanf(line, "%h %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5],
                    f[6]) == 7 && n_ops < MAX_OPS) begin
          g_init[n_ops] = f[0];
          g_wr[n_ops]   = f[1];
          g_addr[n_ops] = f[2];
          g_data[n_ops] = f[3];
          g_strb[n_ops] = f[4];
          g_exp[n_ops]  = f[5];
          g_resp[n_ops] = f[6];
          if (f[2][31:13] == '0) exp_cnt[f[2][12]] += 2;  // Mapped, seen once per pass
          n_ops++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic do_write(input int i, input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, output logic [1:0] rsp);
    logic aw_ok, w_ok, b_ok;
    aw_ok = 1'b0;
    w_ok  = 1'b0;
    b_ok  = 1'b0;
    while (!(aw_ok && w_ok)) begin
      @(negedge clk_i);
      init_reqs[i].aw_valid = !aw_ok;
      init_reqs[i].aw.addr  = addr;
      init_reqs[i].aw.prot  = prot_for(addr);
      init_reqs[i].w_valid  = !w_ok;
      init_reqs[i].w.data   = data;
      init_reqs[i].w.strb   = strb;
      #SKEW;
      if (init_reqs[i].aw_valid && init_resps[i].aw_ready) aw_ok = 1'b1;
      if (init_reqs[i].w_valid && init_resps[i].w_ready) w_ok = 1'b1;
    end
    while (!b_ok) begin
      @(negedge clk_i);
      init_reqs[i].aw_valid = 1'b0;
      init_reqs[i].w_valid  = 1'b0;
      init_reqs[i].b_ready  = ready_draw();
      #SKEW;
      if (init_resps[i].b_valid && init_reqs[i].b_ready) begin
        b_ok = 1'b1;
        rsp  = init_resps[i].b.resp;
      end
    end
  endtask

  task automatic do_read(input int i, input logic [31:0] addr, output logic [31:0] data,
                         output logic [1:0] rsp);
    logic ar_ok, r_ok;
    ar_ok = 1'b0;
    r_ok  = 1'b0;
    while (!ar_ok) begin
      @(negedge clk_i);
      init_reqs[i].ar_valid = 1'b1;
      init_reqs[i].ar.addr  = addr;
      init_reqs[i].ar.prot  = prot_for(addr);
      #SKEW;
      if (init_resps[i].ar_ready) ar_ok = 1'b1;
    end
    while (!r_ok) begin
      @(negedge clk_i);
      init_reqs[i].ar_valid = 1'b0;
      init_reqs[i].r_ready  = ready_draw();
      #SKEW;
      if (init_resps[i].r_valid && init_reqs[i].r_ready) begin
        r_ok = 1'b1;
        data = init_resps[i].r.data;
        rsp  = init_resps[i].r.resp;
      end
    end
  endtask

  task automatic run_init(input int i, input int pass);
    logic [31:0] rd;
    logic [1:0]  rsp;
    int          e0;
    for (int n = 0; n < n_ops; n++) begin
      if (g_init[n] == i) begin
        e0 = errors;
        if (g_wr[n] != 0) begin
          do_write(i, g_addr[n], g_data[n], g_strb[n][3:0], rsp);
          check_val($sformatf("init%0d bresp", i), g_resp[n], 32'(rsp));
        end else begin
          do_read(i, g_addr[n], rd, rsp);
          check_val($sformatf("init%0d rdata", i), g_exp[n], rd);
          check_val($sformatf("init%0d rresp", i), g_resp[n], 32'(rsp));
        end
        if (errors == e0) n_pass++;
        else n_fail++;
        $display("test %0d pass %0d init %0d %s %h %s", n, pass, i,
                 g_wr[n] != 0 ? "write" : "read", g_addr[n], errors == e0 ? "ok" : "bad");
      end
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #(PERIOD / 2) clk_i = ~clk_i;
  end

  // Target memory models
  initial begin
    tgt_resps = '0;
    for (int j = 0; j < N_TGT; j++) begin
      {aw_f[j], w_f[j], b_v[j], r_v[j]} = 4'b0000;
      xfer_cnt[j] = 0;
      for (int k = 0; k < 1024; k++) mem[j][k] = 32'hf000_0000 | (32'(j) << 16) | 32'(k);
    end
    forever begin
      @(negedge clk_i);
      for (int j = 0; j < N_TGT; j++) begin
        tgt_resps[j].aw_ready = !aw_f[j] && ready_draw();
        tgt_resps[j].w_ready  = !w_f[j] && ready_draw();
        tgt_resps[j].b_valid  = b_v[j];
        tgt_resps[j].b.resp   = RESP_OKAY;
        tgt_resps[j].ar_ready = !r_v[j] && ready_draw();
        tgt_resps[j].r_valid  = r_v[j];
        tgt_resps[j].r.data   = r_d[j];
        tgt_resps[j].r.resp   = RESP_OKAY;
      end
      #SKEW;
      for (int j = 0; j < N_TGT; j++) begin
        if (tgt_reqs[j].aw_valid && tgt_resps[j].aw_ready) begin
          aw_f[j]   = 1'b1;
          aw_idx[j] = tgt_reqs[j].aw.addr[11:2];
          check_val($sformatf("tgt%0d awprot", j), 32'(prot_for(tgt_reqs[j].aw.addr)),
                    32'(tgt_reqs[j].aw.prot));
        end
        if (tgt_reqs[j].w_valid && tgt_resps[j].w_ready) begin
          w_f[j] = 1'b1;
          w_d[j] = tgt_reqs[j].w.data;
          w_s[j] = tgt_reqs[j].w.strb;
        end
        if (b_v[j] && tgt_reqs[j].b_ready) b_v[j] = 1'b0;
        if (aw_f[j] && w_f[j]) begin
          for (int b = 0; b < 4; b++)
            if (w_s[j][b]) mem[j][aw_idx[j]][8*b +: 8] = w_d[j][8*b +: 8];
          {aw_f[j], w_f[j], b_v[j]} = 3'b001;
          xfer_cnt[j]++;
        end
        if (tgt_reqs[j].ar_valid && tgt_resps[j].ar_ready) begin
          r_d[j] = mem[j][tgt_reqs[j].ar.addr[11:2]];
          r_v[j] = 1'b1;
          xfer_cnt[j]++;
          check_val($sformatf("tgt%0d arprot", j), 32'(prot_for(tgt_reqs[j].ar.addr)),
                    32'(tgt_reqs[j].ar.prot));
        end else if (r_v[j] && tgt_reqs[j].r_ready) begin
          r_v[j] = 1'b0;
        end
      end
    end
  end

  initial begin
    init_reqs = '0;
    rst_n_i   = 1'b0;
    stall_en  = 1'b0;
    rng       = 32'hee2b_dd45;
    {n_ops, errors, n_pass, n_fail} = '0;
    for (int j = 0; j < N_TGT; j++) exp_cnt[j] = 0;
    load_golden();
    repeat (10) begin
      @(negedge clk_i);
      #SKEW;
      check_val("valid in reset", 32'd0, 32'(any_valid()));
    end
    @(negedge clk_i);
    rst_n_i = 1'b1;
    repeat (2) begin
      @(negedge clk_i);
      #SKEW;
      check_val("valid after reset", 32'd0, 32'(any_valid()));
    end
    for (int pass = 0; pass < 2; pass++) begin
      stall_en = pass[0];  // Second pass with random back-pressure
      fork
        run_init(0, pass);
        run_init(1, pass);
      join
    end
    for (int j = 0; j < N_TGT; j++)
      check_val($sformatf("tgt%0d transfers", j), 32'(exp_cnt[j]), 32'(xfer_cnt[j]));
    $display("tests passed %0d failed %0d, check errors %0d", n_pass, n_fail, errors);
    if (errors == 0 && n_fail == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (n_ops > 0);
    #((n_ops * 40 + 200) * PERIOD);
    $display("timeout: the transactions did not complete in time");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- dv/xbar_golden.txt
# init wr addr wdata strb exp_rdata exp_resp, all hex
# wr 1 is a write, 0 a read; resp 0 OKAY, 3 DECERR
0 1 00000010 deadbeef f 00000000 0
0 0 00000010 00000000 0 deadbeef 0
0 1 00001020 cafef00d f 00000000 0
0 0 00001020 00000000 0 cafef00d 0
0 1 00000010 11223344 5 00000000 0
0 0 00000010 00000000 0 de22be44 0
0 1 20000000 12345678 f 00000000 3
0 0 20000000 00000000 0 00000000 3
1 1 00000100 a5a5a5a5 f 00000000 0
1 0 00000100 00000000 0 a5a5a5a5 0
1 1 00000104 01020304 f 00000000 0
1 0 00000104 00000000 0 01020304 0
1 1 00001100 55aa55aa 3 00000000 0
1 0 00001100 00000000 0 f00155aa 0
1 0 00003000 00000000 0 00000000 3

//--- flist.f
logic/xbar_pkg.sv
logic/xbar_demux.sv
logic/xbar_err_slv.sv
logic/xbar_mux.sv
logic/xbar_top.sv
dv/xbar_chk.sv
dv/tb_xbar.sv

//--- run.sh
#!/bin/sh
# Compile and run the crossbar testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_xbar \
  -Mdir build -o sim_xbar
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./build/sim_xbar > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
  exit 1
fi
exit 0
